//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mmu_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
rtl/mmu_pkg.sv
rtl/cp0_pkg.sv
rtl/addr_xlate.sv
rtl/tlb_cam.sv
rtl/cp0_mmu_regs.sv
rtl/mmu_top.sv
verif/mmu_chk.sv
verif/mmu_tb.sv

//--- rtl/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate (
    input  logic [mmu_pkg::VADDR_W-1:0] i_vaddr,
    input  logic                        i_rd,
    input  logic                        i_wr,
    input  logic                        i_hit,
    input  logic [mmu_pkg::PFN_W-1:0]   i_pfn,
    input  mmu_pkg::cache_attr_t        i_c,
    input  logic                        i_d,
    input  logic                        i_v,
    output logic [mmu_pkg::VADDR_W-1:0] o_paddr,
    output logic                        o_uncached,
    output logic                        o_refill,
    output logic                        o_invalid,
    output logic                        o_modify
);

    localparam int TOP = mmu_pkg::VADDR_W - 1;

    logic                        unmapped;
    logic                        mapped_access;
    logic [mmu_pkg::VADDR_W-1:0] kseg_paddr;
    logic [mmu_pkg::VADDR_W-1:0] tlb_paddr;

    // kseg0 and kseg1 both sit under the 10 prefix
    assign unmapped = (i_vaddr[TOP -: 2] == 2'b10);

    assign kseg_paddr = {3'b000, i_vaddr[TOP-3:0]};
    assign tlb_paddr  = {i_pfn, i_vaddr[mmu_pkg::OFFSET_W-1:0]};

    assign o_paddr    = unmapped ? kseg_paddr : tlb_paddr;

    // kseg1 is the uncached window
    assign o_uncached = unmapped ? i_vaddr[TOP-2] : (i_c == mmu_pkg::C_UNCACHED);

    assign mapped_access = ~unmapped & (i_rd | i_wr);

    assign o_refill  = mapped_access & ~i_hit;
    assign o_invalid = mapped_access & i_hit & ~i_v;

    // store to a clean page
    assign o_modify  = ~unmapped & i_wr & i_hit & i_v & ~i_d;

endmodule

//--- rtl/cp0_mmu_regs.sv
`timescale 1ns/1ps

module cp0_mmu_regs #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_we,
    input  logic [4:0]                       i_waddr,
    input  mmu_pkg::cp0_word_u               i_wdata,
    input  logic [4:0]                       i_raddr,
    input  logic                             i_op_en,
    input  cp0_pkg::tlb_op_e                 i_op,
    input  logic                             i_probe_hit,
    input  logic [$clog2(NUM_ENTRIES)-1:0]   i_probe_index,
    input  mmu_pkg::cp0_word_u               i_rd_entryhi,
    input  mmu_pkg::cp0_word_u               i_rd_pagemask,
    input  mmu_pkg::cp0_word_u               i_rd_entrylo0,
    input  mmu_pkg::cp0_word_u               i_rd_entrylo1,
    output logic [mmu_pkg::VADDR_W-1:0]      o_rdata,
    output mmu_pkg::cp0_word_u               o_entryhi,
    output mmu_pkg::cp0_word_u               o_pagemask,
    output mmu_pkg::cp0_word_u               o_entrylo0,
    output mmu_pkg::cp0_word_u               o_entrylo1,
    output logic [$clog2(NUM_ENTRIES)-1:0]   o_wr_index
);

    localparam int              IDX_W      = $clog2(NUM_ENTRIES);
    localparam logic [IDX_W-1:0] RANDOM_TOP = IDX_W'(NUM_ENTRIES - 1);

    logic               index_p;
    logic [IDX_W-1:0]   index_val;
    logic [IDX_W-1:0]   rand_cnt;
    mmu_pkg::cp0_word_u wr_hi;
    mmu_pkg::cp0_word_u wr_pm;
    mmu_pkg::cp0_word_u wr_lo;

    // only the writable fields survive a CP0 write
    always_comb
    begin
        wr_hi         = '0;
        wr_hi.hi.vpn2 = i_wdata.hi.vpn2;
        wr_hi.hi.asid = i_wdata.hi.asid;
        wr_pm         = '0;
        wr_pm.hi.vpn2 = i_wdata.hi.vpn2;
        wr_lo         = i_wdata;
        wr_lo.lo.zero = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            index_p    <= 1'b0;
            index_val  <= '0;
            o_entryhi  <= '0;
            o_pagemask <= '0;
            o_entrylo0 <= '0;
            o_entrylo1 <= '0;
        end
        else if (i_op_en && i_op == cp0_pkg::TLBP)
        begin
            // a miss sets P and keeps the old index
            index_p <= ~i_probe_hit;
            if (i_probe_hit)
                index_val <= i_probe_index;
        end
        else if (i_op_en && i_op == cp0_pkg::TLBR)
        begin
            o_entryhi  <= i_rd_entryhi;
            o_pagemask <= i_rd_pagemask;
            o_entrylo0 <= i_rd_entrylo0;
            o_entrylo1 <= i_rd_entrylo1;
        end
        else if (i_we)
        begin
            case (i_waddr)
                cp0_pkg::CP0_INDEX:    index_val  <= i_wdata.raw[IDX_W-1:0];
                cp0_pkg::CP0_ENTRYLO0: o_entrylo0 <= wr_lo;
                cp0_pkg::CP0_ENTRYLO1: o_entrylo1 <= wr_lo;
                cp0_pkg::CP0_PAGEMASK: o_pagemask <= wr_pm;
                cp0_pkg::CP0_ENTRYHI:  o_entryhi  <= wr_hi;
                default:               index_val  <= index_val;
            endcase
        end
    end

    // wired is 0, so random walks the whole TLB
    always_ff @(posedge clk)
    begin
        if (rst || rand_cnt == '0)
            rand_cnt <= RANDOM_TOP;
        else
            rand_cnt <= rand_cnt - 1'b1;
    end

    assign o_wr_index = (i_op == cp0_pkg::TLBWR) ? rand_cnt : index_val;

    always_comb
    begin
        case (i_raddr)
            cp0_pkg::CP0_INDEX:    o_rdata = {index_p, {(31 - IDX_W){1'b0}}, index_val};
            cp0_pkg::CP0_RANDOM:   o_rdata = {{(32 - IDX_W){1'b0}}, rand_cnt};
            cp0_pkg::CP0_ENTRYLO0: o_rdata = o_entrylo0.raw;
            cp0_pkg::CP0_ENTRYLO1: o_rdata = o_entrylo1.raw;
            cp0_pkg::CP0_PAGEMASK: o_rdata = o_pagemask.raw;
            cp0_pkg::CP0_ENTRYHI:  o_rdata = o_entryhi.raw;
            default:               o_rdata = '0;
        endcase
    end

endmodule

//--- rtl/cp0_pkg.sv
package cp0_pkg;

    // MMU register numbers in CP0
    localparam logic [4:0] CP0_INDEX    = 5'd0;
    localparam logic [4:0] CP0_RANDOM   = 5'd1;
    localparam logic [4:0] CP0_ENTRYLO0 = 5'd2;
    localparam logic [4:0] CP0_ENTRYLO1 = 5'd3;
    localparam logic [4:0] CP0_PAGEMASK = 5'd5;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;

    // TLB instructions issued with the op strobe
    typedef enum logic [1:0] {
        TLBP  = 2'd0,
        TLBR  = 2'd1,
        TLBWI = 2'd2,
        TLBWR = 2'd3
    } tlb_op_e;

endpackage

//--- rtl/mmu_pkg.sv
package mmu_pkg;

    localparam int VADDR_W  = 32;
    localparam int OFFSET_W = 12;

    // even/odd page pair number, vaddr bits 31:13
    localparam int VPN2_W   = 19;
    localparam int PFN_W    = 20;
    localparam int ASID_W   = 8;

    typedef logic [2:0] cache_attr_t;

    localparam cache_attr_t C_UNCACHED = 3'd2;

    // EntryHi and PageMask layout
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [4:0]        zero;
        logic [ASID_W-1:0] asid;
    } entryhi_t;

    // EntryLo0/EntryLo1 layout
    typedef struct packed {
        logic [5:0]       zero;
        logic [PFN_W-1:0] pfn;
        cache_attr_t      c;
        logic             d;
        logic             v;
        logic             g;
    } entrylo_t;

    // one CP0 word, decoded as hi or lo depending on the register
    typedef union packed {
        logic [VADDR_W-1:0] raw;
        entryhi_t           hi;
        entrylo_t           lo;
    } cp0_word_u;

endpackage

//--- rtl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mmu_pkg::VADDR_W-1:0] i_inst_vaddr,
    input  logic                        i_inst_en,
    input  logic [mmu_pkg::VADDR_W-1:0] i_data_vaddr,
    input  logic                        i_data_rd,
    input  logic                        i_data_wr,
    input  logic                        i_cp0_we,
    input  logic [4:0]                  i_cp0_waddr,
    input  logic [mmu_pkg::VADDR_W-1:0] i_cp0_wdata,
    input  logic [4:0]                  i_cp0_raddr,
    input  logic                        i_tlb_op_en,
    input  cp0_pkg::tlb_op_e            i_tlb_op,
    output logic [mmu_pkg::VADDR_W-1:0] o_inst_paddr,
    output logic                        o_inst_uncached,
    output logic                        o_inst_refill,
    output logic                        o_inst_invalid,
    output logic [mmu_pkg::VADDR_W-1:0] o_data_paddr,
    output logic                        o_data_uncached,
    output logic                        o_data_refill,
    output logic                        o_data_invalid,
    output logic                        o_data_modify,
    output logic [mmu_pkg::VADDR_W-1:0] o_cp0_rdata
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    mmu_pkg::cp0_word_u        entryhi;
    mmu_pkg::cp0_word_u        pagemask;
    mmu_pkg::cp0_word_u        entrylo0;
    mmu_pkg::cp0_word_u        entrylo1;
    mmu_pkg::cp0_word_u        rd_entryhi;
    mmu_pkg::cp0_word_u        rd_pagemask;
    mmu_pkg::cp0_word_u        rd_entrylo0;
    mmu_pkg::cp0_word_u        rd_entrylo1;
    logic [IDX_W-1:0]          wr_index;
    logic [IDX_W-1:0]          probe_index;
    logic                      probe_hit;
    logic                      inst_hit;
    logic [mmu_pkg::PFN_W-1:0] inst_pfn;
    mmu_pkg::cache_attr_t      inst_c;
    logic                      inst_v;
    logic                      data_hit;
    logic [mmu_pkg::PFN_W-1:0] data_pfn;
    mmu_pkg::cache_attr_t      data_c;
    logic                      data_d;
    logic                      data_v;

    cp0_mmu_regs #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_regs (
        .clk(clk),                  .rst(rst),
        .i_we(i_cp0_we),            .i_waddr(i_cp0_waddr),
        .i_wdata(i_cp0_wdata),      .i_raddr(i_cp0_raddr),
        .i_op_en(i_tlb_op_en),      .i_op(i_tlb_op),
        .i_probe_hit(probe_hit),    .i_probe_index(probe_index),
        .i_rd_entryhi(rd_entryhi),  .i_rd_pagemask(rd_pagemask),
        .i_rd_entrylo0(rd_entrylo0), .i_rd_entrylo1(rd_entrylo1),
        .o_rdata(o_cp0_rdata),      .o_entryhi(entryhi),
        .o_pagemask(pagemask),      .o_entrylo0(entrylo0),
        .o_entrylo1(entrylo1),      .o_wr_index(wr_index)
    );

    tlb_cam #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_tlb (
        .clk(clk),                  .rst(rst),
        .i_inst_vaddr(i_inst_vaddr), .i_data_vaddr(i_data_vaddr),
        .i_op_en(i_tlb_op_en),      .i_op(i_tlb_op),
        .i_wr_index(wr_index),      .i_entryhi(entryhi),
        .i_pagemask(pagemask),      .i_entrylo0(entrylo0),
        .i_entrylo1(entrylo1),
        .o_inst_hit(inst_hit),      .o_inst_pfn(inst_pfn),
        .o_inst_c(inst_c),          .o_inst_v(inst_v),
        .o_data_hit(data_hit),      .o_data_pfn(data_pfn),
        .o_data_c(data_c),          .o_data_d(data_d),
        .o_data_v(data_v),
        .o_probe_hit(probe_hit),    .o_probe_index(probe_index),
        .o_rd_entryhi(rd_entryhi),  .o_rd_pagemask(rd_pagemask),
        .o_rd_entrylo0(rd_entrylo0), .o_rd_entrylo1(rd_entrylo1)
    );

    // fetch never writes, so modify stays open here
    addr_xlate u_inst_xlate (
        .i_vaddr(i_inst_vaddr),     .i_rd(i_inst_en),
        .i_wr(1'b0),                .i_hit(inst_hit),
        .i_pfn(inst_pfn),           .i_c(inst_c),
        .i_d(1'b1),                 .i_v(inst_v),
        .o_paddr(o_inst_paddr),     .o_uncached(o_inst_uncached),
        .o_refill(o_inst_refill),   .o_invalid(o_inst_invalid),
        .o_modify()
    );

    addr_xlate u_data_xlate (
        .i_vaddr(i_data_vaddr),     .i_rd(i_data_rd),
        .i_wr(i_data_wr),           .i_hit(data_hit),
        .i_pfn(data_pfn),           .i_c(data_c),
        .i_d(data_d),               .i_v(data_v),
        .o_paddr(o_data_paddr),     .o_uncached(o_data_uncached),
        .o_refill(o_data_refill),   .o_invalid(o_data_invalid),
        .o_modify(o_data_modify)
    );

endmodule

//--- rtl/tlb_cam.sv
`timescale 1ns/1ps

module tlb_cam #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [mmu_pkg::VADDR_W-1:0]      i_inst_vaddr,
    input  logic [mmu_pkg::VADDR_W-1:0]      i_data_vaddr,
    input  logic                             i_op_en,
    input  cp0_pkg::tlb_op_e                 i_op,
    input  logic [$clog2(NUM_ENTRIES)-1:0]   i_wr_index,
    input  mmu_pkg::cp0_word_u               i_entryhi,
    input  mmu_pkg::cp0_word_u               i_pagemask,
    input  mmu_pkg::cp0_word_u               i_entrylo0,
    input  mmu_pkg::cp0_word_u               i_entrylo1,
    output logic                             o_inst_hit,
    output logic [mmu_pkg::PFN_W-1:0]        o_inst_pfn,
    output mmu_pkg::cache_attr_t             o_inst_c,
    output logic                             o_inst_v,
    output logic                             o_data_hit,
    output logic [mmu_pkg::PFN_W-1:0]        o_data_pfn,
    output mmu_pkg::cache_attr_t             o_data_c,
    output logic                             o_data_d,
    output logic                             o_data_v,
    output logic                             o_probe_hit,
    output logic [$clog2(NUM_ENTRIES)-1:0]   o_probe_index,
    output mmu_pkg::cp0_word_u               o_rd_entryhi,
    output mmu_pkg::cp0_word_u               o_rd_pagemask,
    output mmu_pkg::cp0_word_u               o_rd_entrylo0,
    output mmu_pkg::cp0_word_u               o_rd_entrylo1
);

    localparam int IDX_W    = $clog2(NUM_ENTRIES);
    localparam int VPN2_LSB = mmu_pkg::OFFSET_W + 1;

    // G lives apart from the stored EntryHi fields
    logic [mmu_pkg::VPN2_W-1:0] ent_vpn2 [NUM_ENTRIES];
    logic [mmu_pkg::VPN2_W-1:0] ent_mask [NUM_ENTRIES];
    logic [mmu_pkg::ASID_W-1:0] ent_asid [NUM_ENTRIES];
    logic                       ent_g    [NUM_ENTRIES];
    mmu_pkg::cp0_word_u         ent_lo0  [NUM_ENTRIES];
    mmu_pkg::cp0_word_u         ent_lo1  [NUM_ENTRIES];

    logic                        probe;
    logic                        wr_en;
    logic [mmu_pkg::VADDR_W-1:0] data_key;
    logic [mmu_pkg::VPN2_W-1:0]  wr_mask;
    logic [NUM_ENTRIES-1:0]      inst_match;
    logic [NUM_ENTRIES-1:0]      data_match;
    mmu_pkg::cp0_word_u          inst_lo;
    mmu_pkg::cp0_word_u          data_lo;

    function automatic logic [NUM_ENTRIES-1:0] match_vec(
        input logic [mmu_pkg::VPN2_W-1:0] vpn2
    );
        logic [NUM_ENTRIES-1:0] m;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            m[i] = ((vpn2 & ~ent_mask[i]) == ent_vpn2[i])
                && (ent_g[i] || ent_asid[i] == i_entryhi.hi.asid);
        end
        return m;
    endfunction

    // one-hot and-or pick of the even or odd half
    function automatic mmu_pkg::cp0_word_u select_lo(
        input logic [NUM_ENTRIES-1:0] m,
        input logic                   odd
    );
        mmu_pkg::cp0_word_u lo;
        lo.raw = '0;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            lo.raw |= {mmu_pkg::VADDR_W{m[i]}} & (odd ? ent_lo1[i].raw : ent_lo0[i].raw);
        end
        return lo;
    endfunction

    function automatic mmu_pkg::cp0_word_u stored_lo(input mmu_pkg::cp0_word_u w);
        mmu_pkg::cp0_word_u s;
        s        = '0;
        s.lo.pfn = w.lo.pfn & ~{{(mmu_pkg::PFN_W-mmu_pkg::VPN2_W){1'b0}}, wr_mask};
        s.lo.c   = w.lo.c;
        s.lo.d   = w.lo.d;
        s.lo.v   = w.lo.v;
        return s;
    endfunction

    assign probe    = i_op_en && (i_op == cp0_pkg::TLBP);
    assign wr_en    = i_op_en && (i_op == cp0_pkg::TLBWI || i_op == cp0_pkg::TLBWR);
    assign wr_mask  = i_pagemask.hi.vpn2;

    // probe borrows the data port, keyed by EntryHi
    assign data_key = probe ? i_entryhi.raw : i_data_vaddr;

    always_comb
    begin
        inst_match = match_vec(i_inst_vaddr[mmu_pkg::VADDR_W-1:VPN2_LSB]);
        data_match = match_vec(data_key[mmu_pkg::VADDR_W-1:VPN2_LSB]);
        inst_lo    = select_lo(inst_match, i_inst_vaddr[mmu_pkg::OFFSET_W]);
        data_lo    = select_lo(data_match, data_key[mmu_pkg::OFFSET_W]);
    end

    always_comb
    begin
        o_probe_index = '0;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            o_probe_index |= {IDX_W{data_match[i]}} & IDX_W'(i);
        end
    end

    assign o_inst_hit  = |inst_match;
    assign o_inst_pfn  = inst_lo.lo.pfn;
    assign o_inst_c    = inst_lo.lo.c;
    assign o_inst_v    = inst_lo.lo.v;
    assign o_data_hit  = |data_match;
    assign o_data_pfn  = data_lo.lo.pfn;
    assign o_data_c    = data_lo.lo.c;
    assign o_data_d    = data_lo.lo.d;
    assign o_data_v    = data_lo.lo.v;
    assign o_probe_hit = |data_match;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_ENTRIES; i++)
            begin
                ent_vpn2[i] <= '0;
                ent_mask[i] <= '0;
                ent_asid[i] <= '0;
                ent_g[i]    <= 1'b0;
                ent_lo0[i]  <= '0;
                ent_lo1[i]  <= '0;
            end
        end
        else if (wr_en)
        begin
            ent_vpn2[i_wr_index] <= i_entryhi.hi.vpn2 & ~wr_mask;
            ent_mask[i_wr_index] <= wr_mask;
            ent_asid[i_wr_index] <= i_entryhi.hi.asid;
            ent_g[i_wr_index]    <= i_entrylo0.lo.g & i_entrylo1.lo.g;
            ent_lo0[i_wr_index]  <= stored_lo(i_entrylo0);
            ent_lo1[i_wr_index]  <= stored_lo(i_entrylo1);
        end
    end

    // TLBR view of the entry at Index
    always_comb
    begin
        o_rd_entryhi          = '0;
        o_rd_entryhi.hi.vpn2  = ent_vpn2[i_wr_index];
        o_rd_entryhi.hi.asid  = ent_asid[i_wr_index];
        o_rd_pagemask         = '0;
        o_rd_pagemask.hi.vpn2 = ent_mask[i_wr_index];
        o_rd_entrylo0         = ent_lo0[i_wr_index];
        o_rd_entrylo0.lo.g    = ent_g[i_wr_index];
        o_rd_entrylo1         = ent_lo1[i_wr_index];
        o_rd_entrylo1.lo.g    = ent_g[i_wr_index];
    end

endmodule

//--- verif/mmu_chk.sv
`timescale 1ns/1ps

module mmu_chk #(
    parameter int NUM_ENTRIES = 16
) (
    input logic        clk,
    input logic        rst,
    input logic [31:0] i_inst_vaddr,
    input logic [31:0] i_data_vaddr,
    input logic [4:0]  i_cp0_raddr,
    input logic [31:0] i_cp0_rdata,
    input logic        i_inst_refill,
    input logic        i_inst_invalid,
    input logic        i_data_refill,
    input logic        i_data_invalid,
    input logic        i_data_modify
);

    // at most one exception per data access
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({i_data_refill, i_data_invalid, i_data_modify}))
    else
        $error("data port raised more than one exception");

    // kseg0/kseg1 never fault
    assert property (@(posedge clk) disable iff (rst)
        (i_inst_vaddr[31:30] == 2'b10) |-> !(i_inst_refill || i_inst_invalid))
    else
        $error("exception on an unmapped fetch address");

    assert property (@(posedge clk) disable iff (rst)
        (i_data_vaddr[31:30] == 2'b10) |-> !(i_data_refill || i_data_invalid || i_data_modify))
    else
        $error("exception on an unmapped data address");

    // Random steps down by one each cycle and wraps to the top entry
    assert property (@(posedge clk) disable iff (rst)
        (i_cp0_raddr == cp0_pkg::CP0_RANDOM && $past(i_cp0_raddr) == cp0_pkg::CP0_RANDOM
            && !$past(rst))
        |-> (i_cp0_rdata < 32'(NUM_ENTRIES)
            && i_cp0_rdata == (($past(i_cp0_rdata) == 32'd0) ? 32'(NUM_ENTRIES - 1)
                                                              : $past(i_cp0_rdata) - 32'd1)))
    else
        $error("Random register out of range or not counting down");

endmodule

bind mmu_top mmu_chk #(
    .NUM_ENTRIES(NUM_ENTRIES)
) u_chk (
    .clk(clk),                     .rst(rst),
    .i_inst_vaddr(i_inst_vaddr),   .i_data_vaddr(i_data_vaddr),
    .i_cp0_raddr(i_cp0_raddr),     .i_cp0_rdata(o_cp0_rdata),
    .i_inst_refill(o_inst_refill), .i_inst_invalid(o_inst_invalid),
    .i_data_refill(o_data_refill), .i_data_invalid(o_data_invalid),
    .i_data_modify(o_data_modify)
);

//--- verif/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    localparam int NUM_ENTRIES = 16;
    localparam int IDX_W       = $clog2(NUM_ENTRIES);
    // all six tests need a few hundred cycles
    localparam int MAX_CYCLES  = 2000;

    logic             clk = 1'b0;
    logic             rst;
    logic [31:0]      i_inst_vaddr;
    logic             i_inst_en;
    logic [31:0]      i_data_vaddr;
    logic             i_data_rd;
    logic             i_data_wr;
    logic             i_cp0_we;
    logic [4:0]       i_cp0_waddr;
    logic [31:0]      i_cp0_wdata;
    logic [4:0]       i_cp0_raddr;
    logic             i_tlb_op_en;
    cp0_pkg::tlb_op_e i_tlb_op;
    logic [31:0]      o_inst_paddr;
    logic             o_inst_uncached;
    logic             o_inst_refill;
    logic             o_inst_invalid;
    logic [31:0]      o_data_paddr;
    logic             o_data_uncached;
    logic             o_data_refill;
    logic             o_data_invalid;
    logic             o_data_modify;
    logic [31:0]      o_cp0_rdata;

    // reference TLB entries and CP0 registers
    logic [18:0]      ref_vpn2 [NUM_ENTRIES];
    logic [18:0]      ref_mask [NUM_ENTRIES];
    logic [7:0]       ref_asid [NUM_ENTRIES];
    logic             ref_g    [NUM_ENTRIES];
    logic [31:0]      ref_lo   [NUM_ENTRIES][2];
    logic [31:0]      reg_hi;
    logic [31:0]      reg_pm;
    logic [31:0]      reg_lo   [2];
    logic [IDX_W-1:0] reg_index;
    logic [IDX_W-1:0] ref_random;
    logic [31:0]      rng = 32'heb498e3c;
    int               errors = 0;
    int               cycles = 0;

    mmu_top #(.NUM_ENTRIES(NUM_ENTRIES)) dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Random starts at the top entry and counts down, wrapping at 0
    always @(posedge clk)
    begin
        if (rst)
            ref_random <= IDX_W'(NUM_ENTRIES - 1);
        else if (ref_random == '0)
            ref_random <= IDX_W'(NUM_ENTRIES - 1);
        else
            ref_random <= ref_random - 1'b1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // first entry matching on masked VPN2 and on ASID or G, -1 on a miss
    function automatic int ref_find(input logic [31:0] va);
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            if ((va[31:13] & ~ref_mask[i]) == ref_vpn2[i]
                && (ref_g[i] || ref_asid[i] == reg_hi[7:0]))
                return i;
        end
        return -1;
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_flag(input string what, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic cp0_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        i_cp0_we    <= 1'b1;
        i_cp0_waddr <= addr;
        i_cp0_wdata <= data;
        @(posedge clk);
        i_cp0_we    <= 1'b0;
        case (addr)
            cp0_pkg::CP0_INDEX:    reg_index = data[IDX_W-1:0];
            cp0_pkg::CP0_ENTRYLO0: reg_lo[0] = {6'b0, data[25:0]};
            cp0_pkg::CP0_ENTRYLO1: reg_lo[1] = {6'b0, data[25:0]};
            cp0_pkg::CP0_PAGEMASK: reg_pm    = {data[31:13], 13'b0};
            cp0_pkg::CP0_ENTRYHI:  reg_hi    = {data[31:13], 5'b0, data[7:0]};
            default: ;
        endcase
    endtask

    task automatic cp0_check(input logic [4:0] addr, input logic [31:0] exp, input string what);
        @(posedge clk);
        i_cp0_raddr <= addr;
        @(negedge clk);
        expect_eq(what, o_cp0_rdata, exp);
    endtask

    // one-cycle op strobe; slot is Random for TLBWR, else Index
    task automatic tlb_op(input cp0_pkg::tlb_op_e op, output logic [IDX_W-1:0] slot);
        int hit;
        @(posedge clk);
        i_tlb_op_en <= 1'b1;
        i_tlb_op    <= op;
        i_cp0_raddr <= cp0_pkg::CP0_RANDOM;
        @(negedge clk);
        if (op == cp0_pkg::TLBWR)
            expect_eq("Random in the TLBWR cycle", o_cp0_rdata, 32'(ref_random));
        slot = (op == cp0_pkg::TLBWR) ? ref_random : reg_index;
        hit  = ref_find(reg_hi);
        @(posedge clk);
        i_tlb_op_en <= 1'b0;
        if (op == cp0_pkg::TLBP)
        begin
            if (hit >= 0)
                reg_index = IDX_W'(hit);
        end
        else if (op == cp0_pkg::TLBR)
        begin
            reg_hi    = {ref_vpn2[slot], 5'b0, ref_asid[slot]};
            reg_pm    = {ref_mask[slot], 13'b0};
            reg_lo[0] = ref_lo[slot][0] | 32'(ref_g[slot]);
            reg_lo[1] = ref_lo[slot][1] | 32'(ref_g[slot]);
        end
        else
        begin
            ref_vpn2[slot] = reg_hi[31:13] & ~reg_pm[31:13];
            ref_mask[slot] = reg_pm[31:13];
            ref_asid[slot] = reg_hi[7:0];
            ref_g[slot]    = reg_lo[0][0] & reg_lo[1][0];
            for (int h = 0; h < 2; h++)
                ref_lo[slot][h] = {6'b0, reg_lo[h][25:6] & ~{1'b0, reg_pm[31:13]},
                                   reg_lo[h][5:1], 1'b0};
        end
    endtask

    // same address on both ports, fetch plus load or store
    task automatic check_xlate(input logic [31:0] va, input logic wr);
        int          idx;
        logic        unmapped;
        logic        hit;
        logic        unc;
        logic [31:0] lo;
        logic [31:0] paddr;
        @(posedge clk);
        i_inst_vaddr <= va;
        i_inst_en    <= 1'b1;
        i_data_vaddr <= va;
        i_data_rd    <= ~wr;
        i_data_wr    <= wr;
        @(negedge clk);
        unmapped = (va[31:30] == 2'b10);
        idx      = ref_find(va);
        hit      = (idx >= 0);
        lo       = '0;
        if (hit)
            lo = ref_lo[idx][va[12]];
        paddr = unmapped ? {3'b0, va[28:0]} : {lo[25:6], va[11:0]};
        unc   = unmapped ? va[29] : (lo[5:3] == 3'd2);
        if (unmapped || hit)
        begin
            expect_eq("inst paddr", o_inst_paddr, paddr);
            expect_eq("data paddr", o_data_paddr, paddr);
            expect_flag("inst uncached", o_inst_uncached, unc);
            expect_flag("data uncached", o_data_uncached, unc);
        end
        expect_flag("inst refill", o_inst_refill, !unmapped && !hit);
        expect_flag("inst invalid", o_inst_invalid, !unmapped && hit && !lo[1]);
        expect_flag("data refill", o_data_refill, !unmapped && !hit);
        expect_flag("data invalid", o_data_invalid, !unmapped && hit && !lo[1]);
        expect_flag("data modify", o_data_modify, !unmapped && wr && hit && lo[1] && !lo[2]);
    endtask

    task automatic test_unmapped();
        logic [31:0] r;
        for (int n = 0; n < 24; n++)
        begin
            r = next_rand();
            check_xlate({2'b10, r[29:0]}, r[30]);
        end
    endtask

    task automatic test_tlbwi();
        logic [31:0]      r;
        logic [31:0]      lo0;
        logic [31:0]      lo1;
        logic [18:0]      vpn;
        logic [IDX_W-1:0] slot;
        for (int k = 0; k < 8; k++)
        begin
            r   = next_rand();
            lo0 = next_rand();
            lo1 = next_rand();
            vpn = {2'b01, r[11:0], 5'(k)};
            // first two entries global
            if (k < 2)
            begin
                lo0[0] = 1'b1;
                lo1[0] = 1'b1;
            end
            cp0_write(cp0_pkg::CP0_ENTRYHI, {vpn, r[17:13], 8'h3c});
            cp0_write(cp0_pkg::CP0_PAGEMASK, 32'h0);
            cp0_write(cp0_pkg::CP0_ENTRYLO0, lo0);
            cp0_write(cp0_pkg::CP0_ENTRYLO1, lo1);
            cp0_write(cp0_pkg::CP0_INDEX, 32'(k * 2));
            tlb_op(cp0_pkg::TLBWI, slot);
        end
        // second pass runs under a foreign ASID
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                r = next_rand();
                check_xlate({ref_vpn2[2*k], 1'b0, r[11:0]}, r[12]);
                check_xlate({ref_vpn2[2*k], 1'b1, r[23:12]}, r[24]);
            end
            r = next_rand();
            check_xlate({3'b001, r[28:0]}, r[0]);
            cp0_write(cp0_pkg::CP0_ENTRYHI, {reg_hi[31:13], 13'h55});
        end
    endtask

    task automatic test_inv_mod();
        logic [31:0]      r;
        logic [18:0]      vpn;
        logic [IDX_W-1:0] slot;
        r   = next_rand();
        vpn = {2'b01, 12'habc, 5'd20};
        cp0_write(cp0_pkg::CP0_ENTRYHI, {vpn, 5'b0, 8'h55});
        cp0_write(cp0_pkg::CP0_PAGEMASK, 32'h0);
        // even page invalid, odd page valid but clean
        cp0_write(cp0_pkg::CP0_ENTRYLO0, {6'b0, r[19:0], 3'd3, 3'b100});
        cp0_write(cp0_pkg::CP0_ENTRYLO1, {6'b0, r[31:12], 3'd2, 3'b010});
        cp0_write(cp0_pkg::CP0_INDEX, 32'd5);
        tlb_op(cp0_pkg::TLBWI, slot);
        check_xlate({vpn, 1'b0, r[11:0]}, 1'b0);
        check_xlate({vpn, 1'b0, r[11:0]}, 1'b1);
        check_xlate({vpn, 1'b1, r[11:0]}, 1'b0);
        check_xlate({vpn, 1'b1, r[11:0]}, 1'b1);
    endtask

    task automatic test_tlbp();
        logic [31:0]      r;
        logic [IDX_W-1:0] slot;
        for (int k = 0; k < 8; k++)
        begin
            cp0_write(cp0_pkg::CP0_ENTRYHI, {ref_vpn2[2*k], 5'b0, ref_asid[2*k]});
            tlb_op(cp0_pkg::TLBP, slot);
            cp0_check(cp0_pkg::CP0_INDEX, 32'(2 * k), "Index after probe hit");
        end
        // miss keeps the last hit index, 14
        r = next_rand();
        cp0_write(cp0_pkg::CP0_ENTRYHI, {3'b001, r[28:0]});
        tlb_op(cp0_pkg::TLBP, slot);
        cp0_check(cp0_pkg::CP0_INDEX, {1'b1, {(31 - IDX_W){1'b0}}, IDX_W'(14)},
                  "Index after probe miss");
    endtask

    task automatic test_tlbr();
        logic [IDX_W-1:0] slot;
        for (int n = 0; n < 3; n++)
        begin
            cp0_write(cp0_pkg::CP0_INDEX, 32'(n * 3 + 2));
            tlb_op(cp0_pkg::TLBR, slot);
            cp0_check(cp0_pkg::CP0_ENTRYHI, reg_hi, "EntryHi read back");
            cp0_check(cp0_pkg::CP0_PAGEMASK, reg_pm, "PageMask read back");
            cp0_check(cp0_pkg::CP0_ENTRYLO0, reg_lo[0], "EntryLo0 read back");
            cp0_check(cp0_pkg::CP0_ENTRYLO1, reg_lo[1], "EntryLo1 read back");
        end
    endtask

    task automatic test_tlbwr();
        logic [31:0]      r;
        logic [IDX_W-1:0] slot;
        logic [IDX_W-1:0] unused;
        r = next_rand();
        cp0_write(cp0_pkg::CP0_ENTRYHI, {2'b11, r[16:8], 8'h00, 5'b0, 8'h77});
        // low eight VPN2 bits ignored
        cp0_write(cp0_pkg::CP0_PAGEMASK, {19'h000ff, 13'b0});
        cp0_write(cp0_pkg::CP0_ENTRYLO0, next_rand());
        cp0_write(cp0_pkg::CP0_ENTRYLO1, next_rand());
        tlb_op(cp0_pkg::TLBWR, slot);
        tlb_op(cp0_pkg::TLBP, unused);
        cp0_check(cp0_pkg::CP0_INDEX, 32'(slot), "Index after probing the TLBWR entry");
        for (int n = 0; n < 8; n++)
        begin
            r = next_rand();
            check_xlate({reg_hi[31:21], r[7:0], r[8], r[20:9]}, r[21]);
        end
    endtask

    initial
    begin
        rst          = 1'b1;
        i_inst_vaddr = '0;
        i_inst_en    = 1'b0;
        i_data_vaddr = '0;
        i_data_rd    = 1'b0;
        i_data_wr    = 1'b0;
        i_cp0_we     = 1'b0;
        i_cp0_waddr  = '0;
        i_cp0_wdata  = '0;
        i_cp0_raddr  = '0;
        i_tlb_op_en  = 1'b0;
        i_tlb_op     = cp0_pkg::TLBP;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            ref_vpn2[i]  = '0;
            ref_mask[i]  = '0;
            ref_asid[i]  = '0;
            ref_g[i]     = 1'b0;
            ref_lo[i][0] = '0;
            ref_lo[i][1] = '0;
        end
        reg_hi    = '0;
        reg_pm    = '0;
        reg_lo[0] = '0;
        reg_lo[1] = '0;
        reg_index = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_unmapped();
        test_tlbwi();
        test_inv_mod();
        test_tlbp();
        test_tlbr();
        test_tlbwr();
        @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
